//--- design/cpu_pkg.sv
// Shared types, opcodes and instruction decode helpers for the pipelined core and its testbench
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [4:0] {
        op_r_type = 5'b00000,
        op_j      = 5'b00001,
        op_bne    = 5'b00010,
        op_jal    = 5'b00011,
        op_jr     = 5'b00100,
        op_addi   = 5'b00101,
        op_blt    = 5'b00110,
        op_sw     = 5'b00111,
        op_lw     = 5'b01000,
        op_setx   = 5'b10101,
        op_bex    = 5'b10110
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add = 5'b00000,
        alu_sub = 5'b00001,
        alu_and = 5'b00010,
        alu_or  = 5'b00011,
        alu_sll = 5'b00100,
        alu_sra = 5'b00101
    } alu_op_t;

    localparam reg_idx_t status_reg = 5'd30;
    localparam reg_idx_t link_reg   = 5'd31;

    // Codes written to r30 when an arithmetic instruction overflows
    localparam logic [26:0] status_add  = 27'd1;
    localparam logic [26:0] status_addi = 27'd2;
    localparam logic [26:0] status_sub  = 27'd3;

    // Bits 16:0 hold either the R-type fields or the signed immediate
    typedef union packed {
        struct packed {
            reg_idx_t    rt;
            logic [4:0]  shamt;
            alu_op_t     alu_op;
            logic [1:0]  pad;
        } r;
        logic [16:0] imm;
    } ri_low_t;

    typedef union packed {
        struct packed {
            opcode_t  opcode;
            reg_idx_t rd;
            reg_idx_t rs;
            ri_low_t  low;
        } ri;
        struct packed {
            opcode_t     opcode;
            logic [26:0] target;
        } ji;
    } insn_t;

    localparam insn_t nop_insn = '0;

    typedef struct packed {
        word_t pc;
        insn_t insn;
    } fd_t;

    typedef struct packed {
        word_t pc;
        insn_t insn;
        word_t a;
        word_t b;
    } dx_t;

    typedef struct packed {
        insn_t insn;
        word_t o;
        word_t b;
    } xm_t;

    typedef struct packed {
        insn_t insn;
        word_t o;
        word_t d;
    } mw_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic     en;
        reg_idx_t idx;
        word_t    data;
    } wb_t;

    function automatic word_t sext_imm(input insn_t i);
        return {{15{i.ri.low.imm[16]}}, i.ri.low.imm};
    endfunction

    function automatic word_t sext_target(input insn_t i);
        return {{5{i.ji.target[26]}}, i.ji.target};
    endfunction

    // Port A reads rs, except bex which tests r30
    function automatic reg_idx_t read_idx_a(input insn_t i);
        return (i.ji.opcode == op_bex) ? status_reg : i.ri.rs;
    endfunction

    // Branches, jr and sw take their second operand from rd
    function automatic reg_idx_t read_idx_b(input insn_t i);
        case (i.ji.opcode)
            op_bne, op_blt, op_jr, op_sw: return i.ri.rd;
            default: return i.ri.low.r.rt;
        endcase
    endfunction

    function automatic reg_idx_t dest_idx(input insn_t i);
        case (i.ji.opcode)
            op_setx: return status_reg;
            op_jal:  return link_reg;
            default: return i.ri.rd;
        endcase
    endfunction

    function automatic logic writes_reg(input insn_t i);
        case (i.ji.opcode)
            op_r_type, op_addi, op_lw, op_jal, op_setx: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- design/alu.sv
// Combinational ALU of the execute stage with comparison and overflow flags
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    input  logic [4:0]       shamt,
    output cpu_pkg::word_t   y,
    output logic             not_equal,
    output logic             less_than,
    output logic             overflow
);

    cpu_pkg::word_t sum;
    cpu_pkg::word_t diff;
    logic           ov_add;
    logic           ov_sub;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow when the result sign disagrees with both effective operands
    assign ov_add = (a[31] == b[31]) && (sum[31] != a[31]);
    assign ov_sub = (a[31] != b[31]) && (diff[31] != a[31]);

    // Comparisons use a - b, corrected for overflow
    assign not_equal = (diff != '0);
    assign less_than = diff[31] ^ ov_sub;
    assign overflow  = (op == cpu_pkg::alu_sub) ? ov_sub : ov_add;

    always_comb begin
        case (op)
            cpu_pkg::alu_add: y = sum;
            cpu_pkg::alu_sub: y = diff;
            cpu_pkg::alu_and: y = a & b;
            cpu_pkg::alu_or:  y = a | b;
            cpu_pkg::alu_sll: y = a << shamt;
            cpu_pkg::alu_sra: y = cpu_pkg::word_t'($signed(a) >>> shamt);
            default:          y = sum;
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
// Register file of the core, written from writeback and read by decode with write-first ports
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic              clock,
    input  logic              arst_n,
    input  cpu_pkg::reg_idx_t rd_idx_a,
    input  cpu_pkg::reg_idx_t rd_idx_b,
    output cpu_pkg::word_t    rd_a,
    output cpu_pkg::word_t    rd_b,
    input  cpu_pkg::wb_t      wr
);

    // r0 has no storage
    cpu_pkg::word_t regs [1:31];

    always_ff @(posedge clock) begin
        if (wr.en && wr.idx != '0) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // A register written in this cycle reads back its new value
    assign rd_a = (rd_idx_a == '0) ? '0 :
                  (wr.en && wr.idx == rd_idx_a) ? wr.data : regs[rd_idx_a];
    assign rd_b = (rd_idx_b == '0) ? '0 :
                  (wr.en && wr.idx == rd_idx_b) ? wr.data : regs[rd_idx_b];

    // Writeback clears its enable for r0 destinations
    a_no_r0_write: assert property (@(posedge clock) disable iff (!arst_n)
        wr.en |-> wr.idx != '0);

endmodule

`default_nettype wire

//--- design/fetch_decode.sv
// Fetch and decode side of the core: PC, fetch/decode register, operand reads and load-use stall
`timescale 1ns/1ns
`default_nettype none

module fetch_decode #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic                 clock,
    input  logic                 arst_n,
    output cpu_pkg::word_t       address_imem,
    input  cpu_pkg::word_t       q_imem,
    input  cpu_pkg::redirect_t   redirect,
    input  cpu_pkg::insn_t       x_insn,
    output cpu_pkg::reg_idx_t    rd_idx_a,
    output cpu_pkg::reg_idx_t    rd_idx_b,
    input  cpu_pkg::word_t       rd_a,
    input  cpu_pkg::word_t       rd_b,
    output cpu_pkg::dx_t         dx_next,
    output logic                 stall
);

    cpu_pkg::word_t   pc;
    cpu_pkg::word_t   pc_next;
    cpu_pkg::fd_t     fd;
    cpu_pkg::insn_t   d_insn;
    cpu_pkg::opcode_t d_op;
    logic             uses_a;
    logic             uses_b;

    assign address_imem = pc;

    // A taken redirect kills the instruction held in decode
    assign d_insn   = redirect.taken ? cpu_pkg::nop_insn : fd.insn;
    assign d_op     = d_insn.ji.opcode;
    assign rd_idx_a = cpu_pkg::read_idx_a(d_insn);
    assign rd_idx_b = cpu_pkg::read_idx_b(d_insn);

    // Store data is excluded from port B, memory stage forwards it from the load
    always_comb begin
        uses_a = !(d_op inside {cpu_pkg::op_j, cpu_pkg::op_jal, cpu_pkg::op_jr,
                                cpu_pkg::op_setx});
        uses_b = d_op inside {cpu_pkg::op_r_type, cpu_pkg::op_bne, cpu_pkg::op_blt,
                              cpu_pkg::op_jr};
        stall  = (x_insn.ji.opcode == cpu_pkg::op_lw) && (x_insn.ri.rd != '0) &&
                 ((uses_a && x_insn.ri.rd == rd_idx_a) ||
                  (uses_b && x_insn.ri.rd == rd_idx_b));
    end

    always_comb begin
        if (redirect.taken) begin
            pc_next = redirect.target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 32'd1;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    // Fetch/decode register, flushed on redirect and held on stall
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            fd <= '{pc: '0, insn: cpu_pkg::nop_insn};
        end else if (redirect.taken) begin
            fd <= '{pc: pc, insn: cpu_pkg::nop_insn};
        end else if (!stall) begin
            fd <= '{pc: pc, insn: q_imem};
        end
    end

    assign dx_next = '{pc: fd.pc, insn: d_insn, a: rd_a, b: rd_b};

    // A held PC comes with a bubble entering execute
    a_pc_hold: assert property (@(posedge clock) disable iff (!arst_n)
        stall && !redirect.taken |=> $stable(pc) && x_insn == cpu_pkg::nop_insn);

endmodule

`default_nettype wire

//--- design/execute_stage.sv
// Execute stage: operand forwarding, ALU, branch and jump resolution and overflow status rewrite
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                 clock,
    input  logic                 arst_n,
    input  cpu_pkg::dx_t         dx_next,
    input  logic                 stall,
    input  cpu_pkg::xm_t         m_stage,
    input  cpu_pkg::wb_t         wb,
    output cpu_pkg::insn_t       x_insn,
    output cpu_pkg::redirect_t   redirect,
    output cpu_pkg::xm_t         xm
);

    localparam cpu_pkg::dx_t bubble = '{pc: '0, insn: cpu_pkg::nop_insn, a: '0, b: '0};

    cpu_pkg::dx_t     dx;
    cpu_pkg::opcode_t op;
    cpu_pkg::alu_op_t alu_op;
    cpu_pkg::word_t   fwd_a;
    cpu_pkg::word_t   fwd_b;
    cpu_pkg::word_t   opnd_b;
    cpu_pkg::word_t   imm;
    cpu_pkg::word_t   pc1;
    cpu_pkg::word_t   alu_y;
    cpu_pkg::word_t   result;
    cpu_pkg::insn_t   pass_insn;
    logic             ne;
    logic             lt;
    logic             ov;
    logic             is_add;
    logic             is_sub;
    logic [26:0]      status;

    // Memory stage wins over writeback; loads in memory are covered by the stall
    function automatic cpu_pkg::word_t forward(input cpu_pkg::reg_idx_t idx,
                                               input cpu_pkg::word_t rf_val,
                                               input cpu_pkg::xm_t m,
                                               input cpu_pkg::wb_t w);
        if (idx == '0) begin
            return rf_val;
        end
        if (cpu_pkg::writes_reg(m.insn) && m.insn.ji.opcode != cpu_pkg::op_lw &&
            cpu_pkg::dest_idx(m.insn) == idx) begin
            return m.o;
        end
        if (w.en && w.idx == idx) begin
            return w.data;
        end
        return rf_val;
    endfunction

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx <= bubble;
        end else if (stall) begin
            dx <= bubble;
        end else begin
            dx <= dx_next;
        end
    end

    assign x_insn = dx.insn;
    assign op     = dx.insn.ji.opcode;
    assign imm    = cpu_pkg::sext_imm(dx.insn);
    assign pc1    = dx.pc + 32'd1;
    assign fwd_a  = forward(cpu_pkg::read_idx_a(dx.insn), dx.a, m_stage, wb);
    assign fwd_b  = forward(cpu_pkg::read_idx_b(dx.insn), dx.b, m_stage, wb);
    assign opnd_b = (op inside {cpu_pkg::op_addi, cpu_pkg::op_lw, cpu_pkg::op_sw}) ? imm : fwd_b;
    assign alu_op = (op == cpu_pkg::op_r_type) ? dx.insn.ri.low.r.alu_op : cpu_pkg::alu_add;

    alu u_alu (
        .a         (fwd_a),
        .b         (opnd_b),
        .op        (alu_op),
        .shamt     (dx.insn.ri.low.r.shamt),
        .y         (alu_y),
        .not_equal (ne),
        .less_than (lt),
        .overflow  (ov)
    );

    // Branches compare rs (a) against rd (b), so rd < rs means a > b
    always_comb begin
        redirect.taken  = 1'b0;
        redirect.target = cpu_pkg::sext_target(dx.insn);
        case (op)
            cpu_pkg::op_bne: begin
                redirect.taken  = ne;
                redirect.target = pc1 + imm;
            end
            cpu_pkg::op_blt: begin
                redirect.taken  = ne && !lt;
                redirect.target = pc1 + imm;
            end
            cpu_pkg::op_j, cpu_pkg::op_jal: begin
                redirect.taken = 1'b1;
            end
            cpu_pkg::op_jr: begin
                redirect.taken  = 1'b1;
                redirect.target = fwd_b;
            end
            cpu_pkg::op_bex: begin
                redirect.taken = (fwd_a != '0);
            end
            default: begin
            end
        endcase
    end

    assign is_add = (op == cpu_pkg::op_r_type) && (alu_op == cpu_pkg::alu_add);
    assign is_sub = (op == cpu_pkg::op_r_type) && (alu_op == cpu_pkg::alu_sub);

    // An overflowing add, addi or sub becomes a setx of its status code
    always_comb begin
        pass_insn = dx.insn;
        status    = is_sub ? cpu_pkg::status_sub :
                    (op == cpu_pkg::op_addi) ? cpu_pkg::status_addi : cpu_pkg::status_add;
        if (ov && (is_add || is_sub || op == cpu_pkg::op_addi)) begin
            pass_insn.ji.opcode = cpu_pkg::op_setx;
            pass_insn.ji.target = status;
        end
    end

    always_comb begin
        if (pass_insn.ji.opcode == cpu_pkg::op_setx) begin
            result = cpu_pkg::sext_target(pass_insn);
        end else if (op == cpu_pkg::op_jal) begin
            result = pc1;
        end else begin
            result = alu_y;
        end
    end

    assign xm = '{insn: pass_insn, o: result, b: fwd_b};

endmodule

`default_nettype wire

//--- design/mem_wb_stage.sv
// Memory and writeback stages: data-memory port, store data forwarding and register write port
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
    input  logic           clock,
    input  logic           arst_n,
    input  cpu_pkg::xm_t   xm_next,
    output cpu_pkg::xm_t   m_stage,
    output cpu_pkg::word_t address_dmem,
    output cpu_pkg::word_t data,
    output logic           wren,
    input  cpu_pkg::word_t q_dmem,
    output cpu_pkg::wb_t   wb
);

    cpu_pkg::xm_t      m;
    cpu_pkg::mw_t      w;
    cpu_pkg::reg_idx_t dst;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            m <= '{insn: cpu_pkg::nop_insn, o: '0, b: '0};
        end else begin
            m <= xm_next;
        end
    end

    assign m_stage      = m;
    assign address_dmem = m.o;
    assign wren         = (m.insn.ji.opcode == cpu_pkg::op_sw);

    // Store of a register the previous instruction is writing back, e.g. right after lw
    assign data = (wren && wb.en && wb.idx == m.insn.ri.rd) ? wb.data : m.b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            w <= '{insn: cpu_pkg::nop_insn, o: '0, d: '0};
        end else begin
            w <= '{insn: m.insn, o: m.o, d: q_dmem};
        end
    end

    assign dst = cpu_pkg::dest_idx(w.insn);

    always_comb begin
        wb.idx = dst;
        wb.en  = cpu_pkg::writes_reg(w.insn) && (dst != '0);
        case (w.insn.ji.opcode)
            cpu_pkg::op_lw:   wb.data = w.d;
            cpu_pkg::op_setx: wb.data = cpu_pkg::sext_target(w.insn);
            default:          wb.data = w.o;
        endcase
    end

    a_wren_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown(wren));

endmodule

`default_nettype wire

//--- design/cpu_core.sv
// Top level of the five-stage core, exposing the instruction and data memory ports
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic           clock,
    input  logic           arst_n,
    output cpu_pkg::word_t address_imem,
    input  cpu_pkg::word_t q_imem,
    output cpu_pkg::word_t address_dmem,
    output cpu_pkg::word_t data,
    output logic           wren,
    input  cpu_pkg::word_t q_dmem
);

    cpu_pkg::redirect_t redirect;
    cpu_pkg::insn_t     x_insn;
    cpu_pkg::reg_idx_t  rd_idx_a;
    cpu_pkg::reg_idx_t  rd_idx_b;
    cpu_pkg::word_t     rd_a;
    cpu_pkg::word_t     rd_b;
    cpu_pkg::dx_t       dx_next;
    logic               stall;
    cpu_pkg::xm_t       xm;
    cpu_pkg::xm_t       m_stage;
    cpu_pkg::wb_t       wb;

    fetch_decode #(
        .reset_pc (reset_pc)
    ) u_fetch_decode (
        .clock        (clock),
        .arst_n       (arst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .redirect     (redirect),
        .x_insn       (x_insn),
        .rd_idx_a     (rd_idx_a),
        .rd_idx_b     (rd_idx_b),
        .rd_a         (rd_a),
        .rd_b         (rd_b),
        .dx_next      (dx_next),
        .stall        (stall)
    );

    reg_file u_reg_file (
        .clock    (clock),
        .arst_n   (arst_n),
        .rd_idx_a (rd_idx_a),
        .rd_idx_b (rd_idx_b),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .wr       (wb)
    );

    execute_stage u_execute_stage (
        .clock    (clock),
        .arst_n   (arst_n),
        .dx_next  (dx_next),
        .stall    (stall),
        .m_stage  (m_stage),
        .wb       (wb),
        .x_insn   (x_insn),
        .redirect (redirect),
        .xm       (xm)
    );

    mem_wb_stage u_mem_wb_stage (
        .clock        (clock),
        .arst_n       (arst_n),
        .xm_next      (xm),
        .m_stage      (m_stage),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem),
        .wb           (wb)
    );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
// Testbench clock and reset source; a restart pulse holds reset low for a fixed number of cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 8
) (
    input  logic restart,
    output logic clock,
    output logic arst_n
);

    int count;

    initial begin
        clock  = 1'b0;
        arst_n = 1'b0;
        count  = reset_cycles;
    end

    always #(period_ns / 2) clock = ~clock;

    // Reset is released on a rising edge once the count runs out
    always @(posedge clock) begin
        if (restart) begin
            count  <= reset_cycles;
            arst_n <= 1'b0;
        end else if (count > 1) begin
            count <= count - 1;
        end else begin
            count  <= 0;
            arst_n <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_programs.svh
// Test programs, preloaded data words and expected stores, filled in by the CPU testbench at start
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Branch over two marker stores, which appear only when the branch falls through
task automatic branch_case(input cpu_pkg::opcode_t op, input int rd, input int rs,
                           input logic taken, input int addr);
    emit(i_insn(op, rd, rs, 2));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, addr));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, addr + 1));
    if (!taken) begin
        expect_store(addr, 32'h77);
        expect_store(addr + 1, 32'h77);
    end
endtask

task automatic build_tests();
    word_t a;
    word_t b;
    word_t s1;
    word_t s2;
    word_t v [3:8];
    int    x;
    int    y;
    int    z;

    // Test 0: each ALU op uses the result just ahead of it
    start_test(0, "dependent ALU chain");
    draw_bits(16, a);
    draw_bits(16, b);
    draw_bits(5, s1);
    draw_bits(5, s2);
    emit(i_insn(cpu_pkg::op_addi, 1, 0, a));
    emit(i_insn(cpu_pkg::op_addi, 2, 0, b));
    emit(r_insn(3, 1, 2, 0, cpu_pkg::alu_add));
    emit(r_insn(4, 3, 1, 0, cpu_pkg::alu_sub));
    emit(r_insn(5, 4, 3, 0, cpu_pkg::alu_and));
    emit(r_insn(6, 5, 4, 0, cpu_pkg::alu_or));
    emit(r_insn(7, 6, 0, s1, cpu_pkg::alu_sll));
    emit(r_insn(8, 7, 0, s2, cpu_pkg::alu_sra));
    for (int r = 3; r <= 8; r++) begin
        emit(i_insn(cpu_pkg::op_sw, r, 0, 7 + r));
    end
    end_program();
    v[3] = a + b;
    v[4] = v[3] - a;
    v[5] = v[4] & v[3];
    v[6] = v[5] | v[4];
    v[7] = v[6] << s1[4:0];
    // Arithmetic shift as a logical shift with the sign filled in above
    v[8] = (v[7] >> s2[4:0]) | (v[7][31] ? ~(32'hffff_ffff >> s2[4:0]) : 32'h0);
    for (int r = 3; r <= 8; r++) begin
        expect_store(7 + r, v[r]);
    end

    // Test 1: lw then an immediate use, and lw then an immediate store
    start_test(1, "load-use and store forwarding");
    draw_bits(12, a);
    draw_bits(30, b);
    draw_bits(32, s1);
    preload(100, b);
    preload(101, s1);
    emit(i_insn(cpu_pkg::op_addi, 2, 0, a));
    emit(i_insn(cpu_pkg::op_lw, 1, 0, 100));
    emit(r_insn(3, 1, 2, 0, cpu_pkg::alu_add));
    emit(i_insn(cpu_pkg::op_sw, 3, 0, 20));
    emit(i_insn(cpu_pkg::op_sw, 1, 0, 21));
    emit(i_insn(cpu_pkg::op_lw, 4, 0, 101));
    emit(i_insn(cpu_pkg::op_sw, 4, 0, 22));
    end_program();
    expect_store(20, b + a);
    expect_store(21, b);
    expect_store(22, s1);

    // Test 2: bne taken when rd != rs, blt taken when rd < rs signed
    start_test(2, "conditional branches");
    x = -5;
    y = 7;
    z = -9;
    emit(i_insn(cpu_pkg::op_addi, 1, 0, x));
    emit(i_insn(cpu_pkg::op_addi, 2, 0, y));
    emit(i_insn(cpu_pkg::op_addi, 3, 0, z));
    emit(i_insn(cpu_pkg::op_addi, 9, 0, 32'h77));
    branch_case(cpu_pkg::op_bne, 1, 2, x != y, 30);
    branch_case(cpu_pkg::op_bne, 1, 1, x != x, 32);
    branch_case(cpu_pkg::op_blt, 1, 2, x < y, 34);
    branch_case(cpu_pkg::op_blt, 2, 1, y < x, 36);
    branch_case(cpu_pkg::op_blt, 3, 1, z < x, 38);
    end_program();

    // Test 3: j over markers, jal to a store of r31, jr back to the slot after jal
    start_test(3, "jumps");
    emit(i_insn(cpu_pkg::op_addi, 9, 0, 32'h55));
    emit(j_insn(cpu_pkg::op_j, 4));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 40));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 41));
    emit(j_insn(cpu_pkg::op_jal, 8));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 42));
    emit(j_insn(cpu_pkg::op_j, 10));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 43));
    emit(i_insn(cpu_pkg::op_sw, 31, 0, 44));
    emit(i_insn(cpu_pkg::op_jr, 31, 0, 0));
    end_program();
    // jal sits at word 4
    expect_store(44, 32'd5);
    expect_store(42, 32'h55);

    // Test 4: r1 = 0x7fffffff, r5 keeps 9 through three overflows
    start_test(4, "overflow and status");
    emit(i_insn(cpu_pkg::op_addi, 1, 0, 1));
    emit(r_insn(1, 1, 0, 30, cpu_pkg::alu_sll));
    emit(i_insn(cpu_pkg::op_addi, 2, 1, -1));
    emit(r_insn(1, 1, 2, 0, cpu_pkg::alu_add));
    emit(i_insn(cpu_pkg::op_addi, 5, 0, 9));
    emit(i_insn(cpu_pkg::op_addi, 6, 0, -2));
    emit(i_insn(cpu_pkg::op_addi, 9, 0, 32'h66));
    emit(r_insn(5, 1, 1, 0, cpu_pkg::alu_add));
    emit(i_insn(cpu_pkg::op_sw, 30, 0, 50));
    emit(i_insn(cpu_pkg::op_sw, 5, 0, 51));
    emit(i_insn(cpu_pkg::op_addi, 5, 1, 1));
    emit(i_insn(cpu_pkg::op_sw, 30, 0, 52));
    emit(i_insn(cpu_pkg::op_sw, 5, 0, 53));
    emit(r_insn(5, 1, 6, 0, cpu_pkg::alu_sub));
    emit(i_insn(cpu_pkg::op_sw, 30, 0, 54));
    emit(i_insn(cpu_pkg::op_sw, 5, 0, 55));
    emit(j_insn(cpu_pkg::op_setx, 7));
    emit(j_insn(cpu_pkg::op_bex, 20));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 56));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 57));
    emit(j_insn(cpu_pkg::op_setx, 0));
    emit(j_insn(cpu_pkg::op_bex, 24));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 58));
    emit(i_insn(cpu_pkg::op_sw, 9, 0, 59));
    end_program();
    expect_store(50, 32'd1);
    expect_store(51, 32'd9);
    expect_store(52, 32'd2);
    expect_store(53, 32'd9);
    expect_store(54, 32'd3);
    expect_store(55, 32'd9);
    expect_store(58, 32'h66);
    expect_store(59, 32'h66);
endtask

`endif

//--- test/cpu_tb.sv
// Testbench for the pipelined core: runs each program from the table and checks the stores it makes
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    typedef logic [31:0] word_t;

    localparam int period_ns    = 40;
    localparam int reset_cycles = 8;
    localparam int n_tests      = 5;
    localparam int max_words    = 64;
    localparam int max_pre      = 4;
    localparam int max_stores   = 16;
    localparam longint watchdog_ns = n_tests * 200 * period_ns + reset_cycles * period_ns;

    logic  clock;
    logic  arst_n;
    logic  restart;
    word_t address_imem;
    word_t q_imem;
    word_t address_dmem;
    word_t data;
    logic  wren;
    word_t q_dmem;

    word_t imem [0:max_words-1];
    word_t dmem [0:4095];
    word_t got_addr [$];
    word_t got_val [$];
    logic  test_done;
    word_t lfsr_state;

    // Test table, filled by build_tests
    int    cur;
    string test_name [n_tests];
    word_t prog [n_tests][max_words];
    int    prog_len [n_tests];
    word_t pre_addr [n_tests][max_pre];
    word_t pre_val [n_tests][max_pre];
    int    pre_n [n_tests];
    word_t exp_addr [n_tests][max_stores];
    word_t exp_val [n_tests][max_stores];
    int    exp_n [n_tests];
    int    passed;
    int    failed;

    tb_clock #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cycles)
    ) u_clock (
        .restart (restart),
        .clock   (clock),
        .arst_n  (arst_n)
    );

    cpu_core #(
        .reset_pc (32'd0)
    ) DUT (
        .clock        (clock),
        .arst_n       (arst_n),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    // Both memories answer in the same cycle
    assign q_imem = (address_imem < max_words) ? imem[address_imem[5:0]] : '0;
    assign q_dmem = dmem[address_dmem[11:0]];

    // Stores are sampled on the edge that writes them; address 4095 ends a program
    always @(posedge clock) begin
        if (arst_n && wren) begin
            dmem[address_dmem[11:0]] <= data;
            if (address_dmem == 32'd4095) begin
                test_done <= 1'b1;
            end else begin
                got_addr.push_back(address_dmem);
                got_val.push_back(data);
            end
        end
    end

    function automatic word_t lfsr_next(input word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Encoders for the three instruction layouts
    function automatic word_t r_insn(input int rd, input int rs, input int rt, input int shamt,
                                     input cpu_pkg::alu_op_t f);
        return {cpu_pkg::op_r_type, 5'(rd), 5'(rs), 5'(rt), 5'(shamt), f, 2'b00};
    endfunction

    function automatic word_t i_insn(input cpu_pkg::opcode_t op, input int rd, input int rs,
                                     input int n);
        return {op, 5'(rd), 5'(rs), 17'(n)};
    endfunction

    function automatic word_t j_insn(input cpu_pkg::opcode_t op, input int t);
        return {op, 27'(t)};
    endfunction

    task automatic start_test(input int t, input string name);
        cur          = t;
        test_name[t] = name;
        prog_len[t]  = 0;
        pre_n[t]     = 0;
        exp_n[t]     = 0;
    endtask

    task automatic emit(input word_t w);
        prog[cur][prog_len[cur]] = w;
        prog_len[cur]++;
    endtask

    task automatic preload(input word_t addr, input word_t val);
        pre_addr[cur][pre_n[cur]] = addr;
        pre_val[cur][pre_n[cur]]  = val;
        pre_n[cur]++;
    endtask

    task automatic expect_store(input word_t addr, input word_t val);
        exp_addr[cur][exp_n[cur]] = addr;
        exp_val[cur][exp_n[cur]]  = val;
        exp_n[cur]++;
    endtask

    // Closing store to 4095, then a jump to itself
    task automatic end_program();
        emit(i_insn(cpu_pkg::op_sw, 0, 0, 4095));
        emit(j_insn(cpu_pkg::op_j, prog_len[cur]));
    endtask

`include "tb_programs.svh"

    task automatic run_test(input int t);
        int errs;
        int n;
        errs = 0;
        @(posedge clock);
        restart <= 1'b1;
        @(posedge clock);
        restart <= 1'b0;
        wait (!arst_n);
        @(negedge clock);
        for (int i = 0; i < max_words; i++) begin
            imem[i] = (i < prog_len[t]) ? prog[t][i] : '0;
        end
        for (int i = 0; i < 4096; i++) begin
            dmem[i] = 32'hc000_0000 ^ (word_t'(i) * 32'h0001_0003);
        end
        for (int i = 0; i < pre_n[t]; i++) begin
            dmem[pre_addr[t][i][11:0]] = pre_val[t][i];
        end
        got_addr.delete();
        got_val.delete();
        test_done = 1'b0;
        while (!arst_n) @(posedge clock);
        while (!test_done) @(posedge clock);

        n = (got_addr.size() < exp_n[t]) ? got_addr.size() : exp_n[t];
        assert (got_addr.size() == exp_n[t]) else begin
            $display("test %0d made %0d stores where %0d were expected",
                     t, got_addr.size(), exp_n[t]);
            errs++;
        end
        for (int i = 0; i < n; i++) begin
            assert (got_addr[i] == exp_addr[t][i] && got_val[i] == exp_val[t][i]) else begin
                $display("FAIL %0t: test %0d store %0d wrote %h to %0d, expected %h to %0d",
                         $time, t, i, got_val[i], got_addr[i], exp_val[t][i], exp_addr[t][i]);
                errs++;
            end
        end
        if (errs == 0) begin
            passed++;
            $display("PASS test %0d %s", t, test_name[t]);
        end else begin
            failed++;
            $display("FAIL %0t: test %0d %s had %0d errors", $time, t, test_name[t], errs);
        end
    endtask

    initial begin
        restart    = 1'b0;
        test_done  = 1'b0;
        passed     = 0;
        failed     = 0;
        lfsr_state = 32'd80639;
        for (int i = 0; i < max_words; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 4096; i++) begin
            dmem[i] = 32'hc000_0000 ^ (word_t'(i) * 32'h0001_0003);
        end
        build_tests();
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog for a program that never reaches its closing store
    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns before all tests finished", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+test
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/fetch_decode.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_core.sv
test/tb_clock.sv
test/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - design/cpu_pkg.sv
  - design/alu.sv
  - design/reg_file.sv
  - design/fetch_decode.sv
  - design/execute_stage.sv
  - design/mem_wb_stage.sv
  - design/cpu_core.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_clock.sv
      - test/cpu_tb.sv
